// ==== Bender.yml ====
package:
  name: chart_player

sources:
  - hw/rhythm_pkg.sv
  - hw/note_store.sv
  - hw/step_sequencer.sv
  - hw/hit_scorer.sv
  - hw/take_recorder.sv
  - hw/note_voice.sv
  - hw/chart_player_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/chart_player_tb.sv

// ==== hw/chart_player_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module chart_player_top (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  rhythm_pkg::host_req_t          host,
    input  logic [rhythm_pkg::IDX_W-1:0]   chart_len,
    input  logic                           start,
    input  rhythm_pkg::note_u              keys,
    output rhythm_pkg::play_stat_t         stat,
    output logic                           done,
    output logic [rhythm_pkg::SCORE_W-1:0] score,
    output logic                           tone_sig,
    output logic [7:0]                     led,
    output logic                           rd_valid,
    output rhythm_pkg::note_u              rd_data
);

    rhythm_pkg::mem_req_t rec_req;
    rhythm_pkg::mem_req_t seq_req;
    rhythm_pkg::mem_req_t host_mem;
    rhythm_pkg::note_u    cur_note;
    logic                 rec_gnt;
    logic                 seq_gnt;
    logic                 host_gnt;
    logic                 seq_rd_valid;

    // Host is shut out of the store during play
    assign host_mem = '{
        req:   host.en && !stat.playing,
        we:    host.we,
        addr:  {host.take_sel, host.addr},
        wdata: host.data
    };

    note_store u_store (
        .prog_clk(prog_clk), .rst(rst),
        .rec_req(rec_req), .seq_req(seq_req), .host_mem(host_mem),
        .rec_gnt(rec_gnt), .seq_gnt(seq_gnt), .host_gnt(host_gnt),
        .rd_data(rd_data), .seq_rd_valid(seq_rd_valid), .rd_valid(rd_valid)
    );

    step_sequencer u_seq (
        .prog_clk(prog_clk), .rst(rst), .start(start), .chart_len(chart_len),
        .seq_gnt(seq_gnt), .seq_rd_valid(seq_rd_valid), .rd_data(rd_data),
        .seq_req(seq_req), .stat(stat), .cur_note(cur_note), .done(done)
    );

    hit_scorer u_score (
        .prog_clk(prog_clk), .rst(rst), .start(start), .stat(stat),
        .cur_note(cur_note), .keys(keys), .score(score)
    );

    take_recorder u_rec (
        .prog_clk(prog_clk), .rst(rst), .stat(stat), .done(done),
        .keys(keys), .rec_gnt(rec_gnt), .rec_req(rec_req)
    );

    note_voice u_voice (
        .prog_clk(prog_clk), .rst(rst), .stat(stat), .cur_note(cur_note),
        .tone_sig(tone_sig), .led(led)
    );

endmodule

`default_nettype wire

// ==== hw/hit_scorer.sv ====
`timescale 1ns/1ns
`default_nettype none

module hit_scorer (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  logic                           start,
    input  rhythm_pkg::play_stat_t         stat,
    input  rhythm_pkg::note_u              cur_note,
    input  rhythm_pkg::note_u              keys,
    output logic [rhythm_pkg::SCORE_W-1:0] score
);

    logic [rhythm_pkg::OFF_W-1:0]   off_q;
    logic [rhythm_pkg::OFF_W-1:0]   cur_off;
    logic [rhythm_pkg::SCORE_W-1:0] pts;
    logic                           hit_q;
    logic                           in_step;
    logic                           match;

    assign in_step = stat.playing && stat.countdown == 2'd0;
    assign cur_off = stat.step_pulse ? '0 : off_q;

    // Only the first match of a step counts
    assign match = in_step && (stat.step_pulse || !hit_q)
                   && rhythm_pkg::note_valid(cur_note) && keys.raw == cur_note.raw;

    always_comb begin
        if (cur_off < rhythm_pkg::BAND_CYCLES) begin
            pts = rhythm_pkg::SCORE_W'(rhythm_pkg::PTS_PERFECT);
        end else if (cur_off < 2 * rhythm_pkg::BAND_CYCLES) begin
            pts = rhythm_pkg::SCORE_W'(rhythm_pkg::PTS_GREAT);
        end else if (cur_off < 3 * rhythm_pkg::BAND_CYCLES) begin
            pts = rhythm_pkg::SCORE_W'(rhythm_pkg::PTS_GOOD);
        end else begin
            pts = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            off_q <= '0;
            hit_q <= 1'b0;
            score <= '0;
        end else begin
            off_q <= cur_off + 1'b1;
            if (stat.step_pulse) begin
                hit_q <= match;
            end else if (match) begin
                hit_q <= 1'b1;
            end
            if (start) begin
                score <= '0;
            end else if (match) begin
                score <= score + pts;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/note_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module note_store (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  rhythm_pkg::mem_req_t rec_req,
    input  rhythm_pkg::mem_req_t seq_req,
    input  rhythm_pkg::mem_req_t host_mem,
    output logic                 rec_gnt,
    output logic                 seq_gnt,
    output logic                 host_gnt,
    output rhythm_pkg::note_u    rd_data,
    output logic                 seq_rd_valid,
    output logic                 rd_valid
);

    // Chart in the lower half, take in the upper half
    rhythm_pkg::note_u mem [0:2*rhythm_pkg::CHART_DEPTH-1];

    rhythm_pkg::mem_req_t sel;

    // Recorder first, then sequencer, host last
    always_comb begin
        rec_gnt  = rec_req.req;
        seq_gnt  = seq_req.req && !rec_req.req;
        host_gnt = host_mem.req && !rec_req.req && !seq_req.req;
        if (rec_gnt) begin
            sel = rec_req;
        end else if (seq_gnt) begin
            sel = seq_req;
        end else begin
            sel = host_mem;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (sel.req) begin
            if (sel.we) begin
                mem[sel.addr] <= sel.wdata;
            end else begin
                rd_data <= mem[sel.addr];
            end
        end
    end

    // Valid flags tell the reader whose data is on the bus
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            seq_rd_valid <= 1'b0;
            rd_valid     <= 1'b0;
        end else begin
            seq_rd_valid <= seq_gnt && !seq_req.we;
            rd_valid     <= host_gnt && !host_mem.we;
        end
    end

    // A chart read waits at most one cycle behind the recorder
    a_seq_gnt_bound: assert property (
        @(posedge prog_clk) disable iff (rst)
        seq_req.req && !seq_gnt |=> seq_gnt
    );

endmodule

`default_nettype wire

// ==== hw/note_voice.sv ====
`timescale 1ns/1ns
`default_nettype none

module note_voice (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  rhythm_pkg::play_stat_t stat,
    input  rhythm_pkg::note_u      cur_note,
    output logic                   tone_sig,
    output logic [7:0]             led
);

    logic [rhythm_pkg::TONE_W-1:0] half;
    logic [rhythm_pkg::TONE_W-1:0] cnt;
    logic [rhythm_pkg::KEY_W-1:0]  keys_rev;
    logic                          sounding;

    assign half     = rhythm_pkg::tone_half(cur_note);
    assign sounding = stat.playing && stat.countdown == 2'd0 && half != '0;
    // Key C lands on the top LED
    assign keys_rev = {<<{cur_note.f.keys}};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            tone_sig <= 1'b0;
            led      <= '0;
        end else begin
            if (stat.step_pulse) begin
                // Restart the wave in phase with the new note
                cnt      <= rhythm_pkg::TONE_W'(1);
                tone_sig <= 1'b0;
                led      <= {keys_rev, cur_note.f.oct_up | cur_note.f.oct_down};
            end else if (!sounding) begin
                cnt      <= '0;
                tone_sig <= 1'b0;
            end else if (cnt == half) begin
                cnt      <= rhythm_pkg::TONE_W'(1);
                tone_sig <= ~tone_sig;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rhythm_pkg.sv ====
`default_nettype none

package rhythm_pkg;

    localparam int NOTE_W      = 9;
    localparam int KEY_W       = 7;
    localparam int CHART_DEPTH = 64;
    localparam int ADDR_W      = 7;
    localparam int IDX_W       = $clog2(CHART_DEPTH);

    localparam int STEP_CYCLES = 16;
    localparam int COUNT_STEPS = 3;
    localparam int OFF_W       = $clog2(STEP_CYCLES);
    localparam logic [OFF_W-1:0] LAST_CYC = OFF_W'(STEP_CYCLES - 1);

    localparam int BAND_CYCLES = 4;
    localparam int PTS_PERFECT = 10;
    localparam int PTS_GREAT   = 8;
    localparam int PTS_GOOD    = 5;
    localparam int SCORE_W     = 14;

    // Half-period table in prog_clk cycles
    localparam int TONE_W    = 7;
    localparam int TONE_BASE = 20;
    localparam int TONE_STEP = 4;
    localparam int TONE_UP   = 6;
    localparam int TONE_DOWN = 20;

    typedef struct packed {
        logic             oct_down;
        logic             oct_up;
        logic [KEY_W-1:0] keys;
    } note_fields_t;

    typedef union packed {
        logic [NOTE_W-1:0] raw;
        note_fields_t      f;
    } note_u;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        note_u             wdata;
    } mem_req_t;

    typedef struct packed {
        logic             en;
        logic             we;
        logic             take_sel;
        logic [IDX_W-1:0] addr;
        note_u            data;
    } host_req_t;

    typedef struct packed {
        logic             playing;
        logic [1:0]       countdown;
        logic             step_pulse;
        logic [IDX_W-1:0] step_idx;
    } play_stat_t;

    function automatic logic note_valid(input note_u n);
        return $onehot(n.f.keys) && !(n.f.oct_up && n.f.oct_down);
    endfunction

    function automatic logic [TONE_W-1:0] tone_half(input note_u n);
        logic [TONE_W-1:0] base;
        base = '0;
        for (int k = 0; k < KEY_W; k++) begin
            if (n.f.keys[k]) begin
                base = TONE_W'(TONE_BASE + TONE_STEP * k);
            end
        end
        // Zero means silence
        if (!note_valid(n)) begin
            return '0;
        end else if (n.f.oct_up) begin
            return base - TONE_W'(TONE_UP);
        end else if (n.f.oct_down) begin
            return base + TONE_W'(TONE_DOWN);
        end
        return base;
    endfunction

endpackage

`default_nettype wire

// ==== hw/step_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module step_sequencer (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic [rhythm_pkg::IDX_W-1:0]   chart_len,
    input  logic                           seq_gnt,
    input  logic                           seq_rd_valid,
    input  rhythm_pkg::note_u              rd_data,
    output rhythm_pkg::mem_req_t           seq_req,
    output rhythm_pkg::play_stat_t         stat,
    output rhythm_pkg::note_u              cur_note,
    output logic                           done
);

    logic [rhythm_pkg::OFF_W-1:0] cyc;
    logic [rhythm_pkg::IDX_W-1:0] fetch_idx;
    logic                         fetch_go;
    rhythm_pkg::note_u            next_note;

    // Fetch at the start of the last countdown step and of every step
    assign fetch_go  = stat.playing && cyc == '0 && stat.countdown <= 2'd1;
    assign fetch_idx = (stat.countdown != 2'd0) ? '0 : stat.step_idx + 1'b1;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            stat     <= '0;
            cyc      <= '0;
            done     <= 1'b0;
            cur_note <= '0;
        end else begin
            stat.step_pulse <= 1'b0;
            done            <= 1'b0;
            if (start && !stat.playing) begin
                stat.playing   <= 1'b1;
                stat.countdown <= 2'(rhythm_pkg::COUNT_STEPS);
                stat.step_idx  <= '0;
                cyc            <= '0;
                cur_note       <= '0;
            end else if (stat.playing) begin
                cyc <= (cyc == rhythm_pkg::LAST_CYC) ? '0 : cyc + 1'b1;
                if (cyc == rhythm_pkg::LAST_CYC) begin
                    if (stat.countdown != 2'd0) begin
                        stat.countdown <= stat.countdown - 2'd1;
                        if (stat.countdown == 2'd1) begin
                            stat.step_pulse <= 1'b1;
                            cur_note        <= next_note;
                        end
                    end else if (stat.step_idx == chart_len - 1'b1) begin
                        stat.playing <= 1'b0;
                        done         <= 1'b1;
                    end else begin
                        stat.step_idx   <= stat.step_idx + 1'b1;
                        stat.step_pulse <= 1'b1;
                        cur_note        <= next_note;
                    end
                end
            end
        end
    end

    // Chart read, held until the arbiter grants it
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            seq_req <= '0;
        end else if (fetch_go) begin
            seq_req.req  <= 1'b1;
            seq_req.addr <= {1'b0, fetch_idx};
        end else if (seq_gnt) begin
            seq_req.req <= 1'b0;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (seq_rd_valid) begin
            next_note <= rd_data;
        end
    end

    // Prefetched note must be in place when its step starts
    a_fetch_before_pulse: assert property (
        @(posedge prog_clk) disable iff (rst)
        stat.step_pulse |-> !seq_req.req && !seq_rd_valid
    );

endmodule

`default_nettype wire

// ==== hw/take_recorder.sv ====
`timescale 1ns/1ns
`default_nettype none

module take_recorder (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  rhythm_pkg::play_stat_t stat,
    input  logic                   done,
    input  rhythm_pkg::note_u      keys,
    input  logic                   rec_gnt,
    output rhythm_pkg::mem_req_t   rec_req
);

    rhythm_pkg::note_u            keys_q;
    logic [rhythm_pkg::IDX_W-1:0] idx_q;
    logic                         in_step;
    logic                         in_step_q;
    logic                         end_evt;

    assign in_step = stat.playing && stat.countdown == 2'd0;
    // Next pulse or done closes the step that was running last cycle
    assign end_evt = in_step_q && (stat.step_pulse || done);

    always_ff @(posedge prog_clk) begin
        keys_q <= keys;
        idx_q  <= stat.step_idx;
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            in_step_q <= 1'b0;
            rec_req   <= '0;
        end else begin
            in_step_q <= in_step;
            if (end_evt) begin
                rec_req.req   <= 1'b1;
                rec_req.we    <= 1'b1;
                rec_req.addr  <= {1'b1, idx_q};
                rec_req.wdata <= keys_q;
            end else if (rec_gnt) begin
                rec_req.req <= 1'b0;
            end
        end
    end

    // A new step end must not overrun a write still waiting for the store
    a_no_lost_write: assert property (
        @(posedge prog_clk) disable iff (rst)
        end_evt |-> !rec_req.req || rec_gnt
    );

endmodule

`default_nettype wire

// ==== sim/chart_player_ref.svh ====
`ifndef CHART_PLAYER_REF_SVH
`define CHART_PLAYER_REF_SVH

// Note word is {oct_down, oct_up, keys}, key C on bit 0
function automatic logic is_valid_note(input logic [8:0] n);
    int ones;
    ones = 0;
    for (int b = 0; b < 7; b++) begin
        ones += n[b];
    end
    return ones == 1 && !(n[8] && n[7]);
endfunction

function automatic int expected_half(input logic [8:0] n);
    int half;
    half = 0;
    for (int b = 0; b < 7; b++) begin
        if (n[b]) begin
            half = 20 + 4 * b;
        end
    end
    if (!is_valid_note(n)) begin
        half = 0;
    end else if (n[7]) begin
        half = half - 6;
    end else if (n[8]) begin
        half = half + 20;
    end
    return half;
endfunction

function automatic logic [7:0] expected_led(input logic [8:0] n);
    logic [7:0] l;
    l = {7'b0, n[7] | n[8]};
    for (int b = 0; b < 7; b++) begin
        l[7 - b] = n[b];
    end
    return l;
endfunction

function automatic int band_points(input int off);
    if (off < rhythm_pkg::BAND_CYCLES) begin
        return rhythm_pkg::PTS_PERFECT;
    end else if (off < 2 * rhythm_pkg::BAND_CYCLES) begin
        return rhythm_pkg::PTS_GREAT;
    end else if (off < 3 * rhythm_pkg::BAND_CYCLES) begin
        return rhythm_pkg::PTS_GOOD;
    end
    return 0;
endfunction

// Keys still held from the last step count at offset 0
function automatic int step_points(input logic [8:0] note, input logic [8:0] held,
                                   input logic [8:0] press, input int off);
    if (!is_valid_note(note)) begin
        return 0;
    end else if (held == note) begin
        return band_points(0);
    end else if (press == note) begin
        return band_points(off);
    end
    return 0;
endfunction

function automatic logic [8:0] keys_at_step_end(input logic [8:0] held,
                                                input logic [8:0] press, input int off);
    return (off < rhythm_pkg::STEP_CYCLES) ? press : held;
endfunction

`endif

// ==== sim/chart_player_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module chart_player_tb;

    localparam int LEN    = 12;
    localparam int STEP   = rhythm_pkg::STEP_CYCLES;
    localparam int PULSE0 = 1 + rhythm_pkg::COUNT_STEPS * STEP;

    logic                           prog_clk;
    logic                           rst;
    rhythm_pkg::host_req_t          host;
    logic [rhythm_pkg::IDX_W-1:0]   chart_len;
    logic                           start;
    rhythm_pkg::note_u              keys;
    rhythm_pkg::play_stat_t         stat;
    logic                           done;
    logic [rhythm_pkg::SCORE_W-1:0] score;
    logic                           tone_sig;
    logic [7:0]                     led;
    logic                           rd_valid;
    rhythm_pkg::note_u              rd_data;

    logic [8:0] chart [0:rhythm_pkg::CHART_DEPTH-1];
    logic [8:0] exp_take [0:LEN-1];
    int         t = -1;

    `include "chart_player_ref.svh"

    chart_player_top uut (.*);

    always #20 prog_clk = ~prog_clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic wait_event(input logic want_done, input int limit);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge prog_clk);
            seen = want_done ? done : stat.step_pulse;
        end
        if (!seen) begin
            stop_run(want_done ? "Timeout waiting for done" : "Timeout waiting for a step pulse");
        end
    endtask

    task automatic host_access(input logic we, input logic take_sel,
                               input logic [5:0] addr, input logic [8:0] data);
        @(posedge prog_clk);
        #1;
        host.en       = 1'b1;
        host.we       = we;
        host.take_sel = take_sel;
        host.addr     = addr;
        host.data.raw = data;
        @(posedge prog_clk);
        #1;
        host.en = 1'b0;
    endtask

    task automatic read_and_check(input logic take_sel, input logic [5:0] addr,
                                  input logic [8:0] exp, input string name);
        logic seen;
        seen = 1'b0;
        host_access(1'b0, take_sel, addr, '0);
        for (int n = 0; n < 8 && !seen; n++) begin
            @(negedge prog_clk);
            seen = rd_valid;
        end
        if (!seen) begin
            stop_run("Timeout waiting for rd_valid on a host read");
        end
        check_eq(name, rd_data.raw, exp);
    endtask

    function automatic logic [8:0] random_note();
        int oct;
        oct = $urandom % 3;
        return {oct == 2, oct == 1, 7'(7'd1 << ($urandom % 7))};
    endfunction

    // Cycle-exact timeline from the start pulse
    always @(negedge prog_clk) begin
        int s;
        int k;
        if (start) begin
            t = 0;
        end else if (t >= 0) begin
            t = t + 1;
            if (t < PULSE0) begin
                check_eq("stat.countdown", stat.countdown,
                         rhythm_pkg::COUNT_STEPS - (t - 1) / STEP);
                check_eq("stat.playing", stat.playing, 1);
                check_eq("stat.step_pulse", stat.step_pulse, 0);
                check_eq("done", done, 0);
                check_eq("tone_sig", tone_sig, 0);
            end else if (t < PULSE0 + STEP * LEN) begin
                s = (t - PULSE0) / STEP;
                k = (t - PULSE0) % STEP;
                check_eq("stat.countdown", stat.countdown, 0);
                check_eq("stat.playing", stat.playing, 1);
                check_eq("stat.step_pulse", stat.step_pulse, k == 0);
                check_eq("stat.step_idx", stat.step_idx, s);
                check_eq("done", done, 0);
                if (k > 0) begin
                    check_eq("led", led, expected_led(chart[s]));
                    check_eq("tone_sig", tone_sig,
                             expected_half(chart[s]) != 0 && k > expected_half(chart[s]));
                end
            end else begin
                check_eq("done", done, 1);
                check_eq("stat.playing", stat.playing, 0);
                t = -1;
            end
        end
    end

    initial begin
        int         seed;
        int         p;
        int         exp_score;
        logic [8:0] v;
        logic [8:0] held;
        seed      = $urandom(32'h14f1c5c2);
        prog_clk  = 1'b0;
        rst       = 1'b1;
        host      = '0;
        chart_len = LEN;
        start     = 1'b0;
        keys      = '0;
        repeat (2) @(posedge prog_clk);
        #1;
        rst = 1'b0;
        @(negedge prog_clk);
        check_eq("stat.playing", stat.playing, 0);
        check_eq("stat.step_pulse", stat.step_pulse, 0);
        check_eq("done", done, 0);
        check_eq("rd_valid", rd_valid, 0);
        check_eq("tone_sig", tone_sig, 0);
        check_eq("led", led, 0);
        check_eq("score", score, 0);

        for (int a = 0; a < rhythm_pkg::CHART_DEPTH; a++) begin
            chart[a] = random_note();
        end
        // Two invalid notes, the shortest tone and a repeated note
        chart[2] = 9'h003;
        chart[3] = 9'h081;
        chart[6] = chart[5];
        chart[8] = 9'h184;
        for (int a = 0; a < rhythm_pkg::CHART_DEPTH; a++) begin
            host_access(1'b1, 1'b0, a, chart[a]);
        end
        for (int a = 0; a < rhythm_pkg::CHART_DEPTH; a++) begin
            read_and_check(1'b0, a, chart[a], "rd_data");
        end

        @(posedge prog_clk);
        #1;
        start = 1'b1;
        @(posedge prog_clk);
        #1;
        start     = 1'b0;
        held      = '0;
        exp_score = 0;
        for (int i = 0; i < LEN; i++) begin
            wait_event(1'b0, PULSE0 + STEP);
            // An offset of a whole step leaves the keys untouched
            p = 1 + $urandom % STEP;
            v = (($urandom % 4) == 0) ? chart[i] ^ 9'h100 : chart[i];
            exp_score += step_points(chart[i], held, v, p);
            exp_take[i] = keys_at_step_end(held, v, p);
            if (p < STEP) begin
                repeat (p) @(posedge prog_clk);
                #1;
                keys.raw = v;
                held     = v;
            end
        end
        wait_event(1'b1, 2 * STEP);
        check_eq("score", score, exp_score);

        // Recorder stores the last step on the cycle after done
        @(posedge prog_clk);
        for (int i = 0; i < LEN; i++) begin
            read_and_check(1'b1, i, exp_take[i], "take rd_data");
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
hw/rhythm_pkg.sv
hw/note_store.sv
hw/step_sequencer.sv
hw/hit_scorer.sv
hw/take_recorder.sv
hw/note_voice.sv
hw/chart_player_top.sv
sim/chart_player_tb.sv
